/* source/keypad_pkg.sv */
package keypad_pkg;

  // One keypad key, hexadecimal
  typedef logic [3:0] digit_t;

  // Digits held in one keyed frame
  localparam int FRAME_DIGITS = 20;

  // Digit 0 is the most recent key
  typedef digit_t [FRAME_DIGITS-1:0] entry_t;

  // Special key values
  localparam digit_t KEY_ERROR = 4'hE;   // In digit 0, aborted entry
  localparam digit_t KEY_BLANK = 4'hF;   // Pads unused code digits

  // Stored code length limits
  localparam int MIN_CODE_DIGITS = 4;
  localparam int MAX_CODE_DIGITS = 12;

  // User codes held by the lock
  localparam int NUM_CODES = 4;

  typedef entry_t [NUM_CODES-1:0] code_set_t;

endpackage

/* source/lock_pkg.sv */
package lock_pkg;

  // Controller states
  typedef enum logic [3:0] {
    INIT,
    LOCKED,
    AJAR,         // Unlocked, door closed
    OPEN,
    OPEN_ALARM,   // Door open too long
    CHECKING,     // Waiting on the matcher
    WRONG_CODE,
    LOCKOUT,
    ERROR_BEEP,
    DND
  } lock_state_t;

  // Six display digits, digit 0 on the right
  typedef logic [5:0][3:0] status_t;

  localparam status_t STATUS_BLANK = 24'hBBBBBB;
  localparam logic [3:0] STATUS_MARK = 4'hA;   // One per wrong attempt

  // Shared state timer
  localparam int TIMER_W = 16;

  typedef logic [TIMER_W-1:0] timer_t;

  typedef logic [2:0] attempts_t;

endpackage

/* source/code_check_if.sv */
interface code_check_if;

  logic               req_valid;   // One-cycle request pulse
  keypad_pkg::entry_t entry;
  logic               resp_valid;  // Two cycles after req_valid
  logic               match;

  modport requester (
    output req_valid,
    output entry,
    input  resp_valid,
    input  match
  );

  modport matcher (
    input  req_valid,
    input  entry,
    output resp_valid,
    output match
  );

endinterface

/* source/code_matcher.sv */
module code_matcher (
  input  logic                  clk,
  input  logic                  rst,
  input  keypad_pkg::code_set_t codes,
  code_check_if.matcher         chk
);

  // Window positions of the shortest code
  localparam int NUM_SHIFTS = keypad_pkg::FRAME_DIGITS - keypad_pkg::MIN_CODE_DIGITS + 1;
  localparam int DIGIT_W = $bits(keypad_pkg::digit_t);

  typedef logic [keypad_pkg::FRAME_DIGITS-1:0] digit_mask_t;

  digit_mask_t [keypad_pkg::NUM_CODES-1:0] care_d;
  digit_mask_t [keypad_pkg::NUM_CODES-1:0] care_q;
  logic [keypad_pkg::NUM_CODES-1:0]        usable_d;
  logic [keypad_pkg::NUM_CODES-1:0]        usable_q;
  keypad_pkg::entry_t                      entry_q;
  logic                                    valid_s1;
  logic [keypad_pkg::NUM_CODES-1:0]        hit_d;
  logic [keypad_pkg::NUM_CODES-1:0]        hit_q;
  logic                                    valid_s2;

  // Code length is the index of the first blank digit
  always_comb begin
    int len;
    for (int c = 0; c < keypad_pkg::NUM_CODES; c++) begin
      len = keypad_pkg::MAX_CODE_DIGITS;
      for (int d = keypad_pkg::MAX_CODE_DIGITS - 1; d >= 0; d--) begin
        if (codes[c][d] == keypad_pkg::KEY_BLANK)
          len = d;
      end
      usable_d[c] = (len >= keypad_pkg::MIN_CODE_DIGITS);  // Too short never opens
      for (int d = 0; d < keypad_pkg::FRAME_DIGITS; d++)
        care_d[c][d] = (d < len);
    end
  end

  always_ff @(posedge clk) begin
    if (chk.req_valid) begin
      entry_q  <= chk.entry;
      care_q   <= care_d;
      usable_q <= usable_d;
    end
  end

  // Slide each code over the entry
  always_comb begin
    keypad_pkg::entry_t window;
    digit_mask_t        same;
    hit_d = '0;
    for (int k = 0; k < NUM_SHIFTS; k++) begin
      // Blank fill from the top, which never equals a code digit
      window = ~(~entry_q >> (DIGIT_W * k));
      for (int c = 0; c < keypad_pkg::NUM_CODES; c++) begin
        for (int d = 0; d < keypad_pkg::FRAME_DIGITS; d++)
          same[d] = (window[d] == codes[c][d]);
        if (usable_q[c] && ((same | ~care_q[c]) == '1))
          hit_d[c] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_s1)
      hit_q <= hit_d;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= chk.req_valid;
      valid_s2 <= valid_s1;
    end
  end

  assign chk.resp_valid = valid_s2;
  assign chk.match      = |hit_q;   // Any code opens

  // Fixed two-cycle latency, one answer per request
  a_resp_latency: assert property (@(posedge clk) disable iff (rst)
    chk.req_valid |-> ##2 chk.resp_valid);

  a_no_stray_resp: assert property (@(posedge clk) disable iff (rst)
    chk.resp_valid |-> $past(chk.req_valid, 2));

endmodule

/* source/button_debounce.sv */
module button_debounce #(
  parameter int HOLD_CYCLES = 100
) (
  input  logic clk,
  input  logic rst,
  input  logic button,
  output logic pressed
);

  localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

  logic [CNT_W-1:0] hold_cnt;
  logic             fired;   // Set until release

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      hold_cnt <= '0;
      fired    <= 1'b0;
      pressed  <= 1'b0;
    end else begin
      pressed <= 1'b0;
      if (!button) begin
        hold_cnt <= '0;   // Bounce or release restarts the hold
        fired    <= 1'b0;
      end else if (!fired) begin
        if (hold_cnt == CNT_W'(HOLD_CYCLES - 1)) begin
          pressed <= 1'b1;
          fired   <= 1'b1;
        end else begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    pressed |=> !pressed);

endmodule

/* source/lock_fsm.sv */
module lock_fsm #(
  parameter int AUTO_LOCK_CYCLES  = 5000,
  parameter int BEEP_CYCLES       = 50,
  parameter int WRONG_HOLD_CYCLES = 1000,
  parameter int LOCKOUT_CYCLES    = 30000,
  parameter int OPEN_ALARM_CYCLES = 3000,
  parameter int MAX_ATTEMPTS      = 5
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 door_sensor,
  input  logic                 inside_press,
  input  logic                 block_press,
  input  logic                 keypad_valid,
  input  keypad_pkg::entry_t   keypad_digits,
  code_check_if.requester      chk,
  output lock_pkg::status_t    status_digits,
  output logic                 keypad_en,
  output logic                 display_en,
  output logic                 bolt,
  output logic                 beep
);

  localparam lock_pkg::status_t STATUS_LOCKOUT = 24'hBAAAAA;

  lock_pkg::lock_state_t state_q;
  lock_pkg::lock_state_t state_d;
  lock_pkg::timer_t      timer;      // Cycles spent in the current state
  lock_pkg::attempts_t   attempts;
  logic                  error_frame;
  logic                  confirmed;

  assign error_frame = keypad_valid && (keypad_digits[0] == keypad_pkg::KEY_ERROR);
  assign confirmed   = keypad_valid && (keypad_digits[0] != keypad_pkg::KEY_ERROR);

  // Request only when LOCKED takes the entry branch
  assign chk.req_valid = (state_q == lock_pkg::LOCKED) && confirmed &&
                         !block_press && !inside_press;
  assign chk.entry     = keypad_digits;

  always_comb begin
    state_d = state_q;
    case (state_q)
      lock_pkg::INIT: begin
        if (!door_sensor)
          state_d = lock_pkg::LOCKED;
      end
      lock_pkg::LOCKED: begin
        if (error_frame)
          state_d = lock_pkg::ERROR_BEEP;
        else if (block_press)
          state_d = lock_pkg::DND;
        else if (inside_press)
          state_d = lock_pkg::AJAR;
        else if (confirmed)
          state_d = lock_pkg::CHECKING;
      end
      lock_pkg::CHECKING: begin
        if (chk.resp_valid)
          state_d = chk.match ? lock_pkg::AJAR : lock_pkg::WRONG_CODE;
      end
      lock_pkg::AJAR: begin
        if (inside_press)
          state_d = lock_pkg::LOCKED;
        else if (door_sensor)
          state_d = lock_pkg::OPEN;
        else if (timer >= lock_pkg::timer_t'(AUTO_LOCK_CYCLES - 1))
          state_d = lock_pkg::LOCKED;   // Auto relock
      end
      lock_pkg::OPEN: begin
        if (!door_sensor)
          state_d = lock_pkg::AJAR;
        else if (timer >= lock_pkg::timer_t'(OPEN_ALARM_CYCLES - 1))
          state_d = lock_pkg::OPEN_ALARM;
      end
      lock_pkg::OPEN_ALARM: begin
        if (!door_sensor)
          state_d = lock_pkg::AJAR;
      end
      lock_pkg::WRONG_CODE: begin
        if (timer >= lock_pkg::timer_t'(WRONG_HOLD_CYCLES - 1)) begin
          if (attempts >= lock_pkg::attempts_t'(MAX_ATTEMPTS))
            state_d = lock_pkg::LOCKOUT;
          else
            state_d = lock_pkg::LOCKED;
        end
      end
      lock_pkg::LOCKOUT: begin
        if (timer >= lock_pkg::timer_t'(LOCKOUT_CYCLES - 1))
          state_d = lock_pkg::LOCKED;
      end
      lock_pkg::ERROR_BEEP: begin
        if (timer >= lock_pkg::timer_t'(BEEP_CYCLES - 1))
          state_d = lock_pkg::LOCKED;
      end
      lock_pkg::DND: begin
        if (inside_press)
          state_d = lock_pkg::AJAR;
      end
      default: state_d = lock_pkg::INIT;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= lock_pkg::INIT;
      timer   <= '0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q)
        timer <= '0;
      else if (timer != '1)
        timer <= timer + 1'b1;   // Saturates
    end
  end

  // Wrong-attempt count
  always_ff @(posedge clk, posedge rst) begin
    if (rst)
      attempts <= '0;
    else if (state_d == lock_pkg::AJAR && state_q != lock_pkg::AJAR)
      attempts <= '0;
    else if (state_q == lock_pkg::LOCKOUT && state_d != lock_pkg::LOCKOUT)
      attempts <= '0;
    else if (chk.req_valid)
      attempts <= attempts + 1'b1;
  end

  // Outputs follow the current state only
  always_comb begin
    keypad_en     = (state_q == lock_pkg::LOCKED);
    display_en    = (state_q != lock_pkg::DND);
    beep          = (state_q == lock_pkg::ERROR_BEEP) || (state_q == lock_pkg::OPEN_ALARM);
    status_digits = lock_pkg::STATUS_BLANK;
    case (state_q)
      lock_pkg::LOCKED, lock_pkg::CHECKING, lock_pkg::WRONG_CODE,
      lock_pkg::LOCKOUT, lock_pkg::ERROR_BEEP, lock_pkg::DND:
        bolt = 1'b1;
      default:
        bolt = 1'b0;
    endcase
    if (state_q == lock_pkg::WRONG_CODE) begin
      for (int i = 0; i < 6; i++) begin
        if (i < int'(attempts))
          status_digits[i] = lock_pkg::STATUS_MARK;
      end
    end else if (state_q == lock_pkg::LOCKOUT) begin
      status_digits = STATUS_LOCKOUT;
    end
  end

  // Lockout only ends into LOCKED, so the bolt stays thrown across the exit
  a_lockout_bolt: assert property (@(posedge clk) disable iff (rst)
    (state_q == lock_pkg::LOCKOUT) |-> bolt ##1 bolt);

endmodule

/* source/door_lock_top.sv */
module door_lock_top #(
  parameter int AUTO_LOCK_CYCLES  = 5000,
  parameter int DEBOUNCE_CYCLES   = 100,
  parameter int BEEP_CYCLES       = 50,
  parameter int WRONG_HOLD_CYCLES = 1000,
  parameter int LOCKOUT_CYCLES    = 30000,
  parameter int OPEN_ALARM_CYCLES = 3000,
  parameter int MAX_ATTEMPTS      = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  door_sensor,
  input  logic                  inside_button,
  input  logic                  block_button,
  input  logic                  keypad_valid,
  input  keypad_pkg::entry_t    keypad_digits,
  input  keypad_pkg::code_set_t codes,
  output lock_pkg::status_t     status_digits,
  output logic                  keypad_en,
  output logic                  display_en,
  output logic                  bolt,
  output logic                  beep
);

  logic inside_press;
  logic block_press;

  code_check_if chk_if ();

  code_matcher i_code_matcher (
    .clk   (clk),
    .rst   (rst),
    .codes (codes),
    .chk   (chk_if.matcher)
  );

  // Lock and unlock from inside
  button_debounce #(
    .HOLD_CYCLES (DEBOUNCE_CYCLES)
  ) i_inside_debounce (
    .clk     (clk),
    .rst     (rst),
    .button  (inside_button),
    .pressed (inside_press)
  );

  button_debounce #(
    .HOLD_CYCLES (DEBOUNCE_CYCLES)
  ) i_block_debounce (
    .clk     (clk),
    .rst     (rst),
    .button  (block_button),
    .pressed (block_press)
  );

  lock_fsm #(
    .AUTO_LOCK_CYCLES  (AUTO_LOCK_CYCLES),
    .BEEP_CYCLES       (BEEP_CYCLES),
    .WRONG_HOLD_CYCLES (WRONG_HOLD_CYCLES),
    .LOCKOUT_CYCLES    (LOCKOUT_CYCLES),
    .OPEN_ALARM_CYCLES (OPEN_ALARM_CYCLES),
    .MAX_ATTEMPTS      (MAX_ATTEMPTS)
  ) i_lock_fsm (
    .clk           (clk),
    .rst           (rst),
    .door_sensor   (door_sensor),
    .inside_press  (inside_press),
    .block_press   (block_press),
    .keypad_valid  (keypad_valid),
    .keypad_digits (keypad_digits),
    .chk           (chk_if.requester),
    .status_digits (status_digits),
    .keypad_en     (keypad_en),
    .display_en    (display_en),
    .bolt          (bolt),
    .beep          (beep)
  );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, clear of the DUT's clock edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* tb/door_lock_tb.sv */
module door_lock_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int AUTO_LOCK   = 40;
  localparam int DEBOUNCE    = 4;
  localparam int BEEP        = 6;
  localparam int WRONG_HOLD  = 8;
  localparam int LOCKOUT     = 30;
  localparam int OPEN_ALARM  = 20;
  localparam int ATTEMPTS    = 5;
  localparam int SLACK       = 5;
  localparam int CYCLE_LIMIT = 3000;   // About six times the ~500 cycles of all tests

  logic                  clk;
  logic                  rst;
  logic                  door_sensor;
  logic                  inside_button;
  logic                  block_button;
  logic                  keypad_valid;
  keypad_pkg::entry_t    keypad_digits;
  keypad_pkg::code_set_t codes;
  lock_pkg::status_t     status_digits;
  logic                  keypad_en;
  logic                  display_en;
  logic                  bolt;
  logic                  beep;

  int          code_len [keypad_pkg::NUM_CODES];   // Digits in each stored code
  int          checks;
  int          mismatches;
  int          failures;
  int          cycles;
  logic [31:0] lcg_state;

  tb_clock #(.PERIOD(100), .RESET_CYCLES(3)) i_tb_clock (.clk(clk), .rst(rst));

  door_lock_top #(
    .AUTO_LOCK_CYCLES  (AUTO_LOCK),
    .DEBOUNCE_CYCLES   (DEBOUNCE),
    .BEEP_CYCLES       (BEEP),
    .WRONG_HOLD_CYCLES (WRONG_HOLD),
    .LOCKOUT_CYCLES    (LOCKOUT),
    .OPEN_ALARM_CYCLES (OPEN_ALARM),
    .MAX_ATTEMPTS      (ATTEMPTS)
  ) i_door_lock_top (
    .clk           (clk),
    .rst           (rst),
    .door_sensor   (door_sensor),
    .inside_button (inside_button),
    .block_button  (block_button),
    .keypad_valid  (keypad_valid),
    .keypad_digits (keypad_digits),
    .codes         (codes),
    .status_digits (status_digits),
    .keypad_en     (keypad_en),
    .display_en    (display_en),
    .bolt          (bolt),
    .beep          (beep)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic keypad_pkg::digit_t random_digit();
    return keypad_pkg::digit_t'((next_random() >> 16) % 10);   // Plain digits only
  endfunction

  // Low digits hold the code, the rest are blank
  function automatic keypad_pkg::entry_t pad_code(input logic [47:0] value, input int len);
    keypad_pkg::entry_t e;
    for (int i = 0; i < keypad_pkg::FRAME_DIGITS; i++) begin
      e[i] = keypad_pkg::KEY_BLANK;
      if (i < len)
        e[i] = value[4*i +: 4];
    end
    return e;
  endfunction

  // Reference match: some stored code sits anywhere inside the entry
  function automatic logic code_in_entry(input keypad_pkg::entry_t e);
    int   len;
    logic found;
    logic same;
    found = 1'b0;
    for (int c = 0; c < keypad_pkg::NUM_CODES; c++) begin
      len = code_len[c];
      if (len >= keypad_pkg::MIN_CODE_DIGITS) begin
        for (int k = 0; k + len <= keypad_pkg::FRAME_DIGITS; k++) begin
          same = 1'b1;
          for (int d = 0; d < len; d++) begin
            if (e[k + d] != codes[c][d])
              same = 1'b0;
          end
          if (same)
            found = 1'b1;
        end
      end
    end
    return found;
  endfunction

  function automatic keypad_pkg::entry_t entry_with_code(input int c);
    keypad_pkg::entry_t e;
    int                 len;
    int                 offset;
    len = code_len[c];
    for (int i = 0; i < keypad_pkg::FRAME_DIGITS; i++)
      e[i] = random_digit();
    offset = int'(next_random() % 32'(keypad_pkg::FRAME_DIGITS - len + 1));
    for (int d = 0; d < len; d++)
      e[offset + d] = codes[c][d];
    return e;
  endfunction

  function automatic keypad_pkg::entry_t wrong_entry();
    keypad_pkg::entry_t e;
    for (int t = 0; t < 100; t++) begin
      for (int i = 0; i < keypad_pkg::FRAME_DIGITS; i++)
        e[i] = random_digit();
      if (!code_in_entry(e))
        break;
    end
    return e;
  endfunction

  // Expected display after n wrong attempts
  function automatic lock_pkg::status_t marks(input int n);
    lock_pkg::status_t s;
    s = lock_pkg::STATUS_BLANK;
    for (int i = 0; i < n; i++)
      s[i] = lock_pkg::STATUS_MARK;
    return s;
  endfunction

  function automatic logic probe(input string name);
    if (name == "bolt")
      return bolt;
    else if (name == "beep")
      return beep;
    else if (name == "keypad_en")
      return keypad_en;
    return display_en;
  endfunction

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH %s: got 'h%h, expected 'h%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_status(input lock_pkg::status_t actual, input lock_pkg::status_t expected);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH status_digits: got 'h%h, expected 'h%h at %0t",
               actual, expected, $time);
    end
  endtask

  task automatic next_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_for(input string name, input logic value, input int limit);
    int n;
    n = 0;
    while (probe(name) !== value && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (probe(name) !== value) begin
      failures++;
      $display("%s did not reach %0d within %0d cycles at %0t", name, value, limit, $time);
    end
  endtask

  task automatic send_entry(input keypad_pkg::entry_t e);
    keypad_digits = e;
    keypad_valid  = 1'b1;
    next_cycles(1);
    keypad_valid  = 1'b0;
  endtask

  task automatic press_button(input logic is_block, input int hold);
    if (is_block)
      block_button = 1'b1;
    else
      inside_button = 1'b1;
    next_cycles(hold);
    block_button  = 1'b0;
    inside_button = 1'b0;
  endtask

  task automatic reset_defaults();
    @(negedge clk);   // Still in reset
    check_bit("bolt", bolt, 1'b0);
    check_bit("keypad_en", keypad_en, 1'b0);
    check_bit("display_en", display_en, 1'b1);
    check_bit("beep", beep, 1'b0);
    check_status(status_digits, lock_pkg::STATUS_BLANK);
    wait (rst == 1'b0);
    next_cycles(1);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
    check_bit("display_en", display_en, 1'b1);
    check_bit("beep", beep, 1'b0);
    check_status(status_digits, lock_pkg::STATUS_BLANK);
  endtask

  task automatic unlock_each_code();
    for (int c = 0; c < keypad_pkg::NUM_CODES; c++) begin
      send_entry(entry_with_code(c));
      check_bit("bolt", bolt, 1'b1);
      next_cycles(1);
      check_bit("bolt", bolt, 1'b1);
      next_cycles(1);
      check_bit("bolt", bolt, 1'b0);   // Third edge after keypad_valid
      if (c % 2 == 0) begin
        next_cycles(AUTO_LOCK / 2);
        check_bit("bolt", bolt, 1'b0);
        wait_for("bolt", 1'b1, AUTO_LOCK + SLACK);
      end else begin
        door_sensor = 1'b1;
        next_cycles(2);
        check_bit("beep", beep, 1'b0);
        wait_for("beep", 1'b1, OPEN_ALARM + SLACK);
        next_cycles(5);
        check_bit("beep", beep, 1'b1);
        check_bit("bolt", bolt, 1'b0);
        door_sensor = 1'b0;
        next_cycles(1);
        check_bit("beep", beep, 1'b0);
        wait_for("bolt", 1'b1, AUTO_LOCK + SLACK);
      end
      check_bit("keypad_en", keypad_en, 1'b1);
    end
  endtask

  task automatic count_wrong_codes();
    for (int n = 1; n <= ATTEMPTS; n++) begin
      send_entry(wrong_entry());
      next_cycles(2);
      check_status(status_digits, marks(n));
      check_bit("bolt", bolt, 1'b1);
      check_bit("keypad_en", keypad_en, 1'b0);
      if (n < ATTEMPTS)
        wait_for("keypad_en", 1'b1, WRONG_HOLD + SLACK);
    end
    next_cycles(WRONG_HOLD + 1);
    check_status(status_digits, 24'hBAAAAA);   // Lockout display
    check_bit("keypad_en", keypad_en, 1'b0);
    check_bit("bolt", bolt, 1'b1);
    wait_for("keypad_en", 1'b1, LOCKOUT + SLACK);
    check_status(status_digits, lock_pkg::STATUS_BLANK);
    // Count starts over after the lockout
    send_entry(wrong_entry());
    next_cycles(2);
    check_status(status_digits, marks(1));
    wait_for("keypad_en", 1'b1, WRONG_HOLD + SLACK);
  endtask

  task automatic abort_entry_beep();
    keypad_pkg::entry_t e;
    e = wrong_entry();
    e[0] = keypad_pkg::KEY_ERROR;
    send_entry(e);
    check_bit("beep", beep, 1'b1);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b0);
    wait_for("keypad_en", 1'b1, BEEP + SLACK);
    check_bit("beep", beep, 1'b0);
    check_bit("bolt", bolt, 1'b1);
  endtask

  task automatic inside_button_holds();
    press_button(1'b0, DEBOUNCE - 1);   // Too short
    next_cycles(3);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
    inside_button = 1'b1;
    for (int i = 1; i <= DEBOUNCE; i++) begin
      next_cycles(1);
      check_bit("bolt", bolt, 1'b1);
    end
    next_cycles(1);
    check_bit("bolt", bolt, 1'b0);
    next_cycles(2);
    inside_button = 1'b0;
    next_cycles(2);
    check_bit("bolt", bolt, 1'b0);   // One press per hold
    press_button(1'b0, DEBOUNCE + 2);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
  endtask

  task automatic block_button_dnd();
    press_button(1'b1, DEBOUNCE + 2);
    check_bit("display_en", display_en, 1'b0);
    check_bit("keypad_en", keypad_en, 1'b0);
    check_bit("bolt", bolt, 1'b1);
    send_entry(entry_with_code(0));   // Ignored outside LOCKED
    next_cycles(3);
    check_bit("bolt", bolt, 1'b1);
    press_button(1'b0, DEBOUNCE + 2);
    check_bit("bolt", bolt, 1'b0);
    check_bit("display_en", display_en, 1'b1);
    wait_for("bolt", 1'b1, AUTO_LOCK + SLACK);
  endtask

  task automatic print_counts();
    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             checks, mismatches, failures);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      failures++;
      $display("Run stopped after %0d cycles before the tests finished", cycles);
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    checks        = 0;
    mismatches    = 0;
    failures      = 0;
    cycles        = 0;
    lcg_state     = 32'hbb0a;
    door_sensor   = 1'b0;
    inside_button = 1'b0;
    block_button  = 1'b0;
    keypad_valid  = 1'b0;
    keypad_digits = '0;
    code_len[0] = 4;
    code_len[1] = 6;
    code_len[2] = 8;
    code_len[3] = 12;
    codes[0] = pad_code(48'h4321, code_len[0]);
    codes[1] = pad_code(48'h975310, code_len[1]);
    codes[2] = pad_code(48'h86420135, code_len[2]);
    codes[3] = pad_code(48'h314159265358, code_len[3]);

    reset_defaults();
    unlock_each_code();
    count_wrong_codes();
    abort_entry_beep();
    inside_button_holds();
    block_button_dnd();

    print_counts();
    if (mismatches == 0 && failures == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* tb.f */
source/keypad_pkg.sv
source/lock_pkg.sv
source/code_check_if.sv
source/code_matcher.sv
source/button_debounce.sv
source/lock_fsm.sv
source/door_lock_top.sv
tb/tb_clock.sv
tb/door_lock_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= door_lock_tb
RTL_TOP   ?= door_lock_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
